//--- design/milSpi_consts.svh
`ifndef MILSPI_CONSTS_SVH
`define MILSPI_CONSTS_SVH

// data word on both the spi and the mil side
`define MILSPI_WORD_W 16

// ring buffer size in words
`define MILSPI_FIFO_DEPTH 16

`define MILSPI_BLOCK_ADDR 8'hAB

// words in a receive status reply, after the size word
`define MILSPI_STATUS_SIZE 2

`endif

//--- design/milSpiPkg.sv
`default_nettype none

package milSpiPkg;

	// command field in the low byte of the header word
	typedef enum logic [7:0] {
		TCC_UNKNOWN      = 8'd0,
		TCC_RESET        = 8'd1,
		TCC_SEND_DATA    = 8'd2,
		TCC_RECEIVE_STS  = 8'd3,
		TCC_RECEIVE_DATA = 8'd4
	} TCommandCode;

	// frame phase in the spi slave
	typedef enum logic [1:0] {
		LS_IDLE,
		LS_HEADER,
		LS_DATA
	} TLinkState;

endpackage

`default_nettype wire

//--- design/wordFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "milSpi_consts.svh"

module wordFifo #(
	parameter int depth = `MILSPI_FIFO_DEPTH
) (
	input  logic clk, rst,
	input  logic [`MILSPI_WORD_W-1:0] pushData,
	input  logic pushValid,
	output logic [`MILSPI_WORD_W-1:0] popData,
	output logic popValid,
	input  logic popReady,
	output logic [4:0] used
);

	localparam int PtrW = (depth > 1) ? $clog2(depth) : 1;

	logic [`MILSPI_WORD_W-1:0] mem [depth];
	logic [PtrW-1:0] wrPtr, rdPtr;
	logic [4:0] count;
	logic doPush, doPop;

	assign doPush = pushValid && (count != 5'(depth));   // full buffer drops the word
	assign doPop = popValid && popReady;

	assign popValid = (count != 5'd0);
	assign popData = mem[rdPtr];
	assign used = count;

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PtrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PtrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 5'd1;
				2'b01: count <= count - 5'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/spiLink.sv
`timescale 1ns/10ps
`default_nettype none

module spiLink import milSpiPkg::*; (
	input  logic clk, rst, sck, csN, mosi,
	output logic miso,
	output logic [7:0] headerAddr,
	output TCommandCode headerCmd,
	output logic headerValid,
	output logic [15:0] rxWord,
	output logic rxValid,
	input  logic [15:0] txWord,
	input  logic txValid,
	output logic txReady,
	input  logic [15:0] outDataSize
);

	logic sckS1, sckS2, sckPrev;
	logic csS1, csS2;
	logic mosiS1, mosiS2;
	logic sckRise, sckFall;

	TLinkState state;
	logic [3:0] bitCnt;
	logic [15:0] rxShift, rxNext;

	logic sizeLoad;   // held command is valid in this cycle
	logic [15:0] txShift, txNext, txLeft, leftNow;
	logic txNextFull, txTake;

	always_ff @(posedge clk) begin
		if (rst) begin
			{sckS1, sckS2, sckPrev} <= 3'b000;
			{csS1, csS2} <= 2'b11;
			{mosiS1, mosiS2} <= 2'b00;
		end else begin
			{sckPrev, sckS2, sckS1} <= {sckS2, sckS1, sck};
			{csS2, csS1} <= {csS1, csN};
			{mosiS2, mosiS1} <= {mosiS1, mosi};
		end
	end

	assign sckRise = sckS2 & ~sckPrev;
	assign sckFall = ~sckS2 & sckPrev;
	assign rxNext = {rxShift[14:0], mosiS2};   // msb first

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LS_IDLE;
			bitCnt <= '0;
			headerValid <= 1'b0;
			rxValid <= 1'b0;
		end else begin
			headerValid <= 1'b0;
			rxValid <= 1'b0;
			if (csS2) begin
				state <= LS_IDLE;
				bitCnt <= '0;
			end else if (state == LS_IDLE) begin
				state <= LS_HEADER;
			end else if (sckRise) begin
				bitCnt <= bitCnt + 4'd1;
				if (bitCnt == 4'd15) begin
					if (state == LS_HEADER) begin
						headerValid <= 1'b1;
						state <= LS_DATA;
					end else begin
						rxValid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sckRise)
			rxShift <= rxNext;
		if (sckRise && bitCnt == 4'd15 && state == LS_HEADER) begin
			headerAddr <= rxNext[15:8];
			headerCmd <= TCommandCode'(rxNext[7:0]);
		end
		if (sckRise && bitCnt == 4'd15 && state == LS_DATA)
			rxWord <= rxNext;
	end

	// reply sends the size word first, then one prefetched word per boundary
	assign leftNow = sizeLoad ? outDataSize : txLeft;
	assign txReady = (sizeLoad | rxValid) & (leftNow != 16'd0);
	assign txTake = txReady & txValid;

	always_ff @(posedge clk) begin
		if (rst) begin
			sizeLoad <= 1'b0;
			txShift <= '0;
			txLeft <= '0;
			txNextFull <= 1'b0;
			miso <= 1'b0;
		end else begin
			sizeLoad <= headerValid;
			if (csS2) begin
				txShift <= '0;
				txLeft <= '0;
				txNextFull <= 1'b0;
				miso <= 1'b0;
			end else begin
				if (sizeLoad)
					txShift <= outDataSize;
				else if (rxValid)
					txShift <= txNextFull ? txNext : 16'd0;   // zero when nothing was popped
				else if (sckFall)
					txShift <= {txShift[14:0], 1'b0};
				if (sckFall)
					miso <= txShift[15];
				if (sizeLoad | rxValid) begin
					txLeft <= leftNow - {15'd0, txTake};
					txNextFull <= txTake;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (txTake)
			txNext <= txWord;
	end

endmodule

`default_nettype wire

//--- design/statusInfo.sv
`timescale 1ns/10ps
`default_nettype none

`include "milSpi_consts.svh"

module statusInfo (
	input  logic clk, rst,
	input  logic enable,
	input  logic [15:0] statusWord0, statusWord1,
	output logic [15:0] outData,
	output logic outValid,
	input  logic outReady
);

	logic [1:0] idx;
	logic [15:0] snap1;   // second count frozen at the first pop

	assign outValid = enable && (idx < 2'(`MILSPI_STATUS_SIZE));
	assign outData = (idx == 2'd0) ? statusWord0 : snap1;

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			idx <= '0;
		end else if (outValid && outReady) begin
			idx <= idx + 2'd1;
		end
	end

	// word 0 leaves in the same cycle, so only word 1 needs a copy
	always_ff @(posedge clk) begin
		if (enable && outReady && idx == 2'd0)
			snap1 <= statusWord1;
	end

endmodule

`default_nettype wire

//--- design/milSpiBlock.sv
`timescale 1ns/10ps
`default_nettype none

`include "milSpi_consts.svh"

module milSpiBlock import milSpiPkg::*; #(
	parameter logic [7:0] blockAddr = `MILSPI_BLOCK_ADDR
) (
	input  logic clk, rst, csN,
	input  logic [7:0] headerAddr,
	input  TCommandCode headerCmd,
	input  logic headerValid,
	input  logic [`MILSPI_WORD_W-1:0] rxWord,
	input  logic rxValid,
	output logic [`MILSPI_WORD_W-1:0] txWord,
	output logic txValid,
	input  logic txReady,
	output logic [15:0] outDataSize,
	output logic [`MILSPI_WORD_W-1:0] smPushData,
	output logic smPushValid,
	input  logic [`MILSPI_WORD_W-1:0] smPopData,
	input  logic smPopValid,
	output logic smPopReady,
	input  logic [`MILSPI_WORD_W-1:0] msPopData,
	input  logic msPopValid,
	output logic msPopReady,
	input  logic [4:0] smUsed, msUsed,
	output logic [`MILSPI_WORD_W-1:0] milTxData,
	output logic milTxValid,
	input  logic milTxReady,
	output logic resetRequest
);

	TCommandCode filtCmd, cmd;
	logic csS1, csS2;
	logic selSts, selData;
	logic [`MILSPI_WORD_W-1:0] stsData, msCount, smCount;
	logic stsValid, stsReady;

	// foreign addresses never reach the command register
	assign filtCmd = (headerAddr == blockAddr) ? headerCmd : TCC_UNKNOWN;

	always_ff @(posedge clk) begin
		if (rst) begin
			{csS1, csS2} <= 2'b11;
			cmd <= TCC_UNKNOWN;
			resetRequest <= 1'b0;
		end else begin
			{csS2, csS1} <= {csS1, csN};
			if (csS2)
				cmd <= TCC_UNKNOWN;   // frame over
			else if (headerValid)
				cmd <= filtCmd;
			if (headerValid && filtCmd == TCC_RESET)
				resetRequest <= 1'b1;   // sticky until rst
		end
	end

	assign selSts = (cmd == TCC_RECEIVE_STS);
	assign selData = (cmd == TCC_RECEIVE_DATA);

	// spi -> mil only inside a send data frame
	assign smPushData = rxWord;
	assign smPushValid = rxValid && (cmd == TCC_SEND_DATA);

	assign msCount = {{(`MILSPI_WORD_W - 5){1'b0}}, msUsed};
	assign smCount = {{(`MILSPI_WORD_W - 5){1'b0}}, smUsed};

	statusInfo u_statusInfo (
		.clk(clk), .rst(rst),
		.enable(selSts),
		.statusWord0(msCount), .statusWord1(smCount),
		.outData(stsData), .outValid(stsValid), .outReady(stsReady)
	);

	// reply source
	assign txWord = selSts ? stsData : msPopData;
	assign txValid = selSts ? stsValid : (selData && msPopValid);
	assign stsReady = selSts && txReady;
	assign msPopReady = selData && txReady;

	always_comb begin
		case (cmd)
			TCC_RECEIVE_STS:  outDataSize = 16'(`MILSPI_STATUS_SIZE);
			TCC_RECEIVE_DATA: outDataSize = 16'(msCount);   // sampled before the first pop
			default:          outDataSize = '0;
		endcase
	end

	// mil pusher drives the head of smFifo whenever the buffer holds a word
	assign milTxData = smPopData;
	assign milTxValid = smPopValid;
	assign smPopReady = milTxReady;

endmodule

`default_nettype wire

//--- design/milSpiTop.sv
`timescale 1ns/10ps
`default_nettype none

`include "milSpi_consts.svh"

module milSpiTop import milSpiPkg::*; (
	input  logic clk, rst, sck, csN, mosi,
	output logic miso,
	input  logic [`MILSPI_WORD_W-1:0] milRxData,
	input  logic milRxValid,
	output logic [`MILSPI_WORD_W-1:0] milTxData,
	output logic milTxValid,
	input  logic milTxReady,
	output logic resetRequest
);

	logic [7:0] headerAddr;
	TCommandCode headerCmd;
	logic headerValid, rxValid, txValid, txReady;
	logic [`MILSPI_WORD_W-1:0] rxWord, txWord;
	logic [15:0] outDataSize;
	logic [`MILSPI_WORD_W-1:0] smPushData, smPopData, msPopData;
	logic smPushValid, smPopValid, smPopReady;
	logic msPopValid, msPopReady;
	logic [4:0] smUsed, msUsed;

	spiLink u_spiLink (
		.clk(clk), .rst(rst), .sck(sck), .csN(csN), .mosi(mosi), .miso(miso),
		.headerAddr(headerAddr), .headerCmd(headerCmd), .headerValid(headerValid),
		.rxWord(rxWord), .rxValid(rxValid),
		.txWord(txWord), .txValid(txValid), .txReady(txReady),
		.outDataSize(outDataSize)
	);

	milSpiBlock #(.blockAddr(`MILSPI_BLOCK_ADDR)) u_milSpiBlock (
		.clk(clk), .rst(rst), .csN(csN),
		.headerAddr(headerAddr), .headerCmd(headerCmd), .headerValid(headerValid),
		.rxWord(rxWord), .rxValid(rxValid),
		.txWord(txWord), .txValid(txValid), .txReady(txReady),
		.outDataSize(outDataSize),
		.smPushData(smPushData), .smPushValid(smPushValid),
		.smPopData(smPopData), .smPopValid(smPopValid), .smPopReady(smPopReady),
		.msPopData(msPopData), .msPopValid(msPopValid), .msPopReady(msPopReady),
		.smUsed(smUsed), .msUsed(msUsed),
		.milTxData(milTxData), .milTxValid(milTxValid), .milTxReady(milTxReady),
		.resetRequest(resetRequest)
	);

	// spi -> mil
	wordFifo #(.depth(`MILSPI_FIFO_DEPTH)) smFifo (
		.clk(clk), .rst(rst),
		.pushData(smPushData), .pushValid(smPushValid),
		.popData(smPopData), .popValid(smPopValid), .popReady(smPopReady),
		.used(smUsed)
	);

	// mil -> spi fed straight from the link layer
	wordFifo #(.depth(`MILSPI_FIFO_DEPTH)) msFifo (
		.clk(clk), .rst(rst),
		.pushData(milRxData), .pushValid(milRxValid),
		.popData(msPopData), .popValid(msPopValid), .popReady(msPopReady),
		.used(msUsed)
	);

endmodule

`default_nettype wire

//--- sim/milSpi_chk.sv
`timescale 1ns/10ps
`default_nettype none

module milSpi_chk (
	input logic clk, rst,
	input logic [15:0] milTxData,
	input logic milTxValid, milTxReady, resetRequest, headerValid
);

	int fails = 0;

	// word on the mil port waits for the link layer
	txHold: assert property (@(posedge clk) disable iff (rst)
		milTxValid && !milTxReady |=> milTxValid && $stable(milTxData))
		else begin
			$error("milTxData changed or dropped while milTxReady was low");
			fails++;
		end

	resetSticky: assert property (@(posedge clk) $fell(resetRequest) |-> $past(rst))
		else begin
			$error("resetRequest fell without rst");
			fails++;
		end

	headerPulse: assert property (@(posedge clk) disable iff (rst)
		headerValid |=> !headerValid)
		else begin
			$error("headerValid held longer than one cycle");
			fails++;
		end

endmodule

`default_nettype wire

//--- sim/milSpiMon.sv
`timescale 1ns/10ps
`default_nettype none

module milSpiMon (
	input  logic clk, sck, csN, miso,
	input  logic [15:0] milTxData,
	input  logic milTxValid, milTxReady, resetRequest,
	input  logic [15:0] expTxData, expRxData,
	input  logic expTxPush, expRxPush, rowDone, expReset,
	output int txPending, checks, errors
);

	logic [15:0] expTx [$];
	logic [15:0] expRx [$];
	logic [15:0] shiftIn = '0;
	logic [15:0] expWord;
	logic sckPrev = 1'b0;
	int bitIdx = 0;
	int wordIdx = 0;   // word 0 is the header
	int rowNum = 0;
	int rowErrors = 0;
	int checkCount = 0;
	int errCount = 0;
	int pendCount = 0;

	assign txPending = pendCount;
	assign checks = checkCount;
	assign errors = errCount;

	task automatic mismatch(input string sig, input logic [15:0] exp, input logic [15:0] got);
		$display("FAIL %s exp %h got %h", sig, exp, got);
		rowErrors++;
	endtask

	always @(posedge clk) begin
		if (expTxPush)
			expTx.push_back(expTxData);
		if (expRxPush)
			expRx.push_back(expRxData);
		if (milTxValid && milTxReady) begin
			checkCount++;
			if (expTx.size() == 0) begin
				$display("unexpected word %h on milTxData", milTxData);
				rowErrors++;
			end else begin
				expWord = expTx.pop_front();
				if (milTxData !== expWord)
					mismatch("milTxData", expWord, milTxData);
			end
		end
		if (csN) begin
			bitIdx = 0;
			wordIdx = 0;
		end else if (sck && !sckPrev) begin
			shiftIn = {shiftIn[14:0], miso};   // sampled like the master, on rising sck
			bitIdx++;
			if (bitIdx == 16) begin
				bitIdx = 0;
				if (wordIdx > 0) begin
					checkCount++;
					if (expRx.size() == 0) begin
						$display("reply word %h arrived with none expected", shiftIn);
						rowErrors++;
					end else begin
						expWord = expRx.pop_front();
						if (shiftIn !== expWord)
							mismatch("miso", expWord, shiftIn);
					end
				end
				wordIdx++;
			end
		end
		sckPrev = sck;
		if (rowDone) begin
			checkCount++;
			if (resetRequest !== expReset)
				mismatch("resetRequest", {15'd0, expReset}, {15'd0, resetRequest});
			$display("row %0d %s, %0d errors", rowNum, (rowErrors == 0) ? "ok" : "failed",
				rowErrors);
			errCount += rowErrors;
			rowErrors = 0;
			rowNum++;
		end
		pendCount = expTx.size();
	end

endmodule

`default_nettype wire

//--- sim/milSpiTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "milSpi_consts.svh"

module milSpiTb import milSpiPkg::*; ();

	typedef struct packed {
		logic [7:0] addr;
		TCommandCode cmd;   // TCC_UNKNOWN row pulses rst instead of a frame
		logic [7:0] nData;
		logic [31:0] dataSeed;
		logic ready;
		logic [7:0] inject;   // words pushed on milRx before the frame
	} TRow;

	localparam int NumRows = 10;

	logic clk, rst, sck, csN, mosi, miso;
	logic [15:0] milRxData, milTxData;
	logic milRxValid, milTxValid, milTxReady, resetRequest;
	logic [15:0] expTxData, expRxData;
	logic expTxPush, expRxPush, rowDone, expReset;
	int txPending, checks, errors;
	logic drainTimeout;

	TRow rows [NumRows];
	logic [15:0] frameWords [$];
	logic [15:0] msModel [$];   // words sitting in msFifo
	int smPend;                 // words parked in smFifo while milTxReady is low
	integer seed;

	milSpiTop u_milSpiTop (.*);
	milSpiMon u_mon (.*);

	bind milSpiTop milSpi_chk u_chk (.clk, .rst, .milTxData, .milTxValid, .milTxReady,
		.resetRequest, .headerValid);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic queueMilWord(input logic [15:0] w);
		expTxData = w;
		expTxPush = 1'b1;
		@(negedge clk);
		expTxPush = 1'b0;
	endtask

	// expected miso word and mosi word for one slot after the header
	task automatic queueSlot(input logic [15:0] reply, input logic [15:0] sent);
		expRxData = reply;
		expRxPush = 1'b1;
		frameWords.push_back(sent);
		@(negedge clk);
		expRxPush = 1'b0;
	endtask

	// mode 0 master at 8 clk per sck
	task automatic spiFrame();
		csN = 1'b0;
		repeat (4) @(negedge clk);
		foreach (frameWords[i]) begin
			for (int b = 15; b >= 0; b--) begin
				mosi = frameWords[i][b];
				repeat (4) @(negedge clk);
				sck = 1'b1;
				repeat (4) @(negedge clk);
				sck = 1'b0;
			end
		end
		repeat (8) @(negedge clk);
		csN = 1'b1;
		mosi = 1'b0;
		repeat (8) @(negedge clk);
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		while (txPending != 0 && n < 400) begin
			@(negedge clk);
			n++;
		end
		if (txPending != 0) begin
			$display("timeout, %0d words never appeared on milTxData", txPending);
			drainTimeout = 1'b1;
		end
	endtask

	task automatic runRow(input TRow row);
		logic [15:0] w;
		logic own;
		int n;
		own = (row.addr == `MILSPI_BLOCK_ADDR);
		seed = row.dataSeed;
		milTxReady = row.ready;
		if (row.cmd == TCC_UNKNOWN) begin
			rst = 1'b1;
			repeat (3) @(negedge clk);
			rst = 1'b0;
			expReset = 1'b0;
			msModel.delete();
			smPend = 0;
		end else begin
			for (int i = 0; i < row.inject; i++) begin
				w = 16'($random(seed));
				milRxData = w;
				milRxValid = 1'b1;
				msModel.push_back(w);
				@(negedge clk);
			end
			milRxValid = 1'b0;
			frameWords.delete();
			frameWords.push_back({row.addr, row.cmd});
			case (row.cmd)
				TCC_SEND_DATA: begin
					for (int i = 0; i < row.nData; i++) begin
						w = 16'($random(seed));
						if (own && (row.ready || smPend < `MILSPI_FIFO_DEPTH)) begin
							queueMilWord(w);
							if (!row.ready)
								smPend++;
						end
						queueSlot(16'h0000, w);   // miso stays low in a send frame
					end
				end
				TCC_RECEIVE_STS: begin
					queueSlot(16'(`MILSPI_STATUS_SIZE), 16'h0000);
					queueSlot(16'(msModel.size()), 16'h0000);
					queueSlot(16'(smPend), 16'h0000);
				end
				TCC_RECEIVE_DATA: begin
					n = msModel.size();
					queueSlot(16'(n), 16'h0000);
					for (int i = 0; i < n; i++)
						queueSlot(msModel.pop_front(), 16'h0000);
				end
				default: if (own) expReset = 1'b1;   // reset frame is header only
			endcase
			spiFrame();
		end
		if (row.ready) begin
			waitDrain();
			smPend = 0;
		end
		rowDone = 1'b1;
		@(negedge clk);
		rowDone = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		sck = 1'b0;
		csN = 1'b1;
		mosi = 1'b0;
		milRxData = '0;
		milRxValid = 1'b0;
		milTxReady = 1'b0;
		expTxData = '0;
		expRxData = '0;
		expTxPush = 1'b0;
		expRxPush = 1'b0;
		rowDone = 1'b0;
		expReset = 1'b0;
		drainTimeout = 1'b0;
		smPend = 0;
		seed = 32'h9373;
		rows[0] = '{8'hAB, TCC_SEND_DATA, 8'd5, 32'h9373, 1'b1, 8'd0};
		rows[1] = '{8'h12, TCC_SEND_DATA, 8'd4, 32'h9374, 1'b1, 8'd0};   // foreign address
		rows[2] = '{8'hAB, TCC_RECEIVE_STS, 8'd0, 32'h0, 1'b1, 8'd0};
		rows[3] = '{8'hAB, TCC_SEND_DATA, 8'd20, 32'h9375, 1'b0, 8'd0};  // overfills smFifo
		rows[4] = '{8'hAB, TCC_RECEIVE_STS, 8'd0, 32'h0, 1'b0, 8'd0};
		rows[5] = '{8'h3C, TCC_RESET, 8'd0, 32'h0, 1'b0, 8'd0};
		rows[6] = '{8'hAB, TCC_RESET, 8'd0, 32'h0, 1'b0, 8'd0};
		rows[7] = '{8'hAB, TCC_RECEIVE_DATA, 8'd0, 32'h9376, 1'b1, 8'd5};  // releases milTx
		rows[8] = '{8'hAB, TCC_RECEIVE_DATA, 8'd0, 32'h0, 1'b1, 8'd0};
		rows[9] = '{8'h00, TCC_UNKNOWN, 8'd0, 32'h0, 1'b1, 8'd0};
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int r = 0; r < NumRows && !drainTimeout; r++)
			runRow(rows[r]);
		repeat (4) @(negedge clk);
		$display("%0d rows, %0d checks, %0d errors, %0d assertion failures", NumRows, checks,
			errors, u_milSpiTop.u_chk.fails);
		if (errors == 0 && u_milSpiTop.u_chk.fails == 0 && !drainTimeout) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- milSpi.f
+incdir+design
design/milSpiPkg.sv
design/wordFifo.sv
design/spiLink.sv
design/statusInfo.sv
design/milSpiBlock.sv
design/milSpiTop.sv
sim/milSpi_chk.sv
sim/milSpiMon.sv
sim/milSpiTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := milSpiTb
FILELIST  := milSpi.f
OBJDIR    := obj_dir
SIMARGS   := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
